// ==== testbench/flash_cmd_patterns.mem ====
// Columns: cmd addr len seed busy, all hex
// cmd 0 read, 1 program, 2 sector erase, 3 wipe; cmd ff ends the list
0 000010 0008 00 00
1 000020 0010 10 03
0 000020 0010 00 00
1 000020 0008 03 02
0 000018 0018 00 00
1 000800 0020 a0 05
0 000800 0020 00 00
2 000800 0001 00 06
0 000800 0010 00 00
0 000020 0004 00 00
1 000f00 000c 55 01
0 000f00 000c 00 00
3 000000 0001 00 08
0 000005 0004 00 00
0 000ff0 0010 00 00
ff 000000 0000 00 00

// ==== sources.f ====
+incdir+design
design/flash_cmd_pkg.sv
design/spi_bus_pkg.sv
design/spi_byte_shifter.sv
design/spi_bus_arbiter.sv
design/flash_cmd_engine.sv
design/flash_busy_poller.sv
design/qspi_flash_ctrl.sv
testbench/tb_clock_gen.sv
testbench/spi_flash_model.sv
testbench/tb_qspi_flash_ctrl.sv

// ==== Makefile ====
TOP             ?= tb_qspi_flash_ctrl
SIM_DIR         ?= sim_build
VERILATOR       ?= verilator
VERILATOR_FLAGS ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

# Build and run, exit status is the test result
sim:
	$(VERILATOR) $(VERILATOR_FLAGS) --top-module $(TOP) -Mdir $(SIM_DIR) -f sources.f
	./$(SIM_DIR)/V$(TOP)

clean:
	rm -rf $(SIM_DIR)

// ==== testbench/tb_qspi_flash_ctrl.sv ====
`timescale 1ns/1ps
`include "qspi_flash_defines.svh"

module tb_qspi_flash_ctrl;

	localparam int CLKDIV  = 1;
	localparam int MAX_PAT = 32;
	localparam int PAT_W   = 5; // Words per pattern line

	logic                      clk, rst_n;
	logic [`QSPI_CLKDIV_W-1:0] clkdiv;
	logic                      cmd_en;
	flash_cmd_pkg::host_cmd_t  cmd_id;
	logic [`QSPI_ADDR_W-1:0]   cmd_addr;
	logic [`QSPI_LEN_W-1:0]    cmd_len;
	logic [7:0]                read_data, write_data;
	logic                      read_valid, write_valid, write_ready, busy;
	logic                      spi_sck, spi_mosi, spi_miso, spi_cs_n;
	logic [7:0]                busy_reads;
	logic [31:0]               busy_polls;

	logic [31:0] pat [0:MAX_PAT*PAT_W-1];
	logic [7:0]  shadow [0:4095]; // Expected flash contents
	integer      seed = 32'he806_1ff6;
	int          rd_total, rd_base, wr_total, wr_base;
	logic        cur_is_read;
	logic [11:0] cur_addr;
	logic [7:0]  cur_seed;
	longint      cycles, limit;

	tb_clock_gen i_clk (.clk, .rst_n);

	qspi_flash_ctrl i_dut (
		.clk, .rst_n, .clkdiv, .cmd_en, .cmd_id, .cmd_addr, .cmd_len,
		.read_data, .read_valid, .write_data, .write_valid, .write_ready, .busy,
		.spi_sck, .spi_mosi, .spi_miso, .spi_cs_n
	);

	spi_flash_model i_flash (
		.clk, .rst_n, .spi_sck, .spi_mosi, .spi_cs_n, .spi_miso, .busy_reads, .busy_polls
	);

	//////////////////////////////////////////////////
	// Error exits

	task automatic report_mismatch(input string name, input logic [31:0] got,
	                               input logic [31:0] exp);
		$display("** Error at %0t ns: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
		$display("SIMULATION FAILED");
		$fatal(1, "Stopped at first mismatch");
	endtask

	task automatic report_problem(input string what);
		$display("Error at %0t ns: %s", $time, what);
		$display("SIMULATION FAILED");
		$fatal(1, "Stopped at first error");
	endtask

	// Run limit from the pattern lengths
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (limit > 0 && cycles > limit) begin
			$display("Timeout after %0d cycles, busy never fell", cycles);
			$display("SIMULATION FAILED");
			$fatal(1, "Timeout");
		end
	end

	// Read data checker
	always @(posedge clk) begin : read_monitor
		logic [7:0] exp;
		if (rst_n && read_valid) begin
			assert (cur_is_read) else report_problem("read_valid pulsed outside a read");
			exp = shadow[cur_addr + 12'(rd_total - rd_base)];
			assert (read_data == exp) else report_mismatch("read_data", read_data, exp);
			rd_total = rd_total + 1;
		end
	end

	// Host side of program, answers write_ready after a random delay
	initial begin : write_responder
		int unsigned delay;
		logic [7:0]  data;
		forever begin
			@(posedge clk);
			if (write_ready) begin
				delay    = {$random(seed)} % 21;
				data     = cur_seed + 8'(wr_total - wr_base); // Seed plus index
				wr_total = wr_total + 1;
				repeat (delay) @(posedge clk);
				write_data  <= data;
				write_valid <= 1'b1;
				@(posedge clk);
				write_valid <= 1'b0;
			end
		end
	end

	//////////////////////////////////////////////////
	// One host command, start to busy low

	task automatic run_command(input logic [31:0] c, input logic [31:0] a,
	                           input logic [31:0] l, input logic [31:0] s,
	                           input logic [31:0] b);
		int rd0, wr0;
		logic [31:0] pol0;
		rd0  = rd_total;
		wr0  = wr_total;
		pol0 = busy_polls;
		@(posedge clk);
		cur_is_read = (c == 0);
		cur_addr    = a[11:0];
		cur_seed    = s[7:0];
		rd_base     = rd_total;
		wr_base     = wr_total;
		cmd_id      <= flash_cmd_pkg::host_cmd_t'(c[1:0]);
		cmd_addr    <= a[23:0];
		cmd_len     <= l[15:0];
		busy_reads  <= b[7:0];
		cmd_en      <= 1'b1;
		@(posedge clk);
		cmd_en <= 1'b0;
		while (!busy)
			@(posedge clk);
		while (busy)
			@(posedge clk);
		cur_is_read = 1'b0;

		if (c == 0) begin
			assert (rd_total - rd0 == int'(l))
				else report_mismatch("read_valid count", rd_total - rd0, l);
		end else begin
			// Busy must have been polled through in the model
			assert (busy_polls - pol0 == b)
				else report_mismatch("busy status reads", busy_polls - pol0, b);
		end
		if (c == 1) begin
			assert (wr_total - wr0 == int'(l))
				else report_mismatch("write_ready count", wr_total - wr0, l);
			for (int i = 0; i < int'(l); i++)
				shadow[a[11:0] + 12'(i)] = shadow[a[11:0] + 12'(i)] & (s[7:0] + 8'(i));
		end else begin
			assert (wr_total == wr0) else report_problem("write_ready pulsed outside program");
		end
		if (c == 2 || c == 3) begin
			for (int i = 0; i < 4096; i++)
				shadow[i] = 8'hff;
		end
	endtask

	initial begin : main_flow
		int n;
		clkdiv      = `QSPI_CLKDIV_W'(CLKDIV);
		cmd_en      = 1'b0;
		cmd_id      = flash_cmd_pkg::HOST_READ;
		cmd_addr    = '0;
		cmd_len     = 1;
		write_valid = 1'b0;
		write_data  = '0;
		busy_reads  = '0;
		cur_is_read = 1'b0;
		cur_addr    = '0;
		cur_seed    = '0;
		rd_total    = 0;
		rd_base     = 0;
		wr_total    = 0;
		wr_base     = 0;
		cycles      = 0;
		limit       = 0;
		for (int i = 0; i < 4096; i++)
			shadow[i] = 8'hff;

		$readmemh("testbench/flash_cmd_patterns.mem", pat);
		n = 0;
		while (n < MAX_PAT && pat[PAT_W*n] != 32'hff) begin
			limit = limit + longint'(pat[PAT_W*n+2] + 8 + pat[PAT_W*n+4]) * 16 * (CLKDIV + 1)
			        + 200;
			n++;
		end
		assert (n > 0) else report_problem("no command patterns found");

		wait (rst_n);
		@(posedge clk);
		assert (busy == 1'b0) else report_mismatch("busy", busy, 0);
		assert (spi_cs_n == 1'b1) else report_mismatch("spi_cs_n", spi_cs_n, 1);

		for (int i = 0; i < n; i++)
			run_command(pat[PAT_W*i], pat[PAT_W*i+1], pat[PAT_W*i+2], pat[PAT_W*i+3],
			            pat[PAT_W*i+4]);

		repeat (4) @(posedge clk);
		if (cycles <= limit) begin
			$display("SIMULATION PASSED");
			$finish;
		end else begin
			$display("SIMULATION FAILED");
			$fatal(1, "Run limit exceeded");
		end
	end

endmodule

// ==== testbench/spi_flash_model.sv ====
`timescale 1ns/1ps

module spi_flash_model #(
	parameter int MEM_BYTES = 4096
) (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        spi_sck,
	input  logic        spi_mosi,
	input  logic        spi_cs_n,
	output logic        spi_miso,
	input  logic [7:0]  busy_reads,  // Status reads that report busy
	output logic [31:0] busy_polls   // Busy status bytes handed out so far
);

	logic [7:0]  mem [0:MEM_BYTES-1];
	logic        sck_q, cs_q;       // Pin history, edges seen on clk
	logic [2:0]  bit_cnt;
	int          byte_cnt;          // Bytes done in this transaction
	logic [7:0]  opcode;
	logic [23:0] addr;
	logic [7:0]  rx_sh, tx_sh, nxt_byte;
	logic        wel;               // Write enable latch
	int          busy_left;

	// Erased part at power up
	initial begin
		for (int i = 0; i < MEM_BYTES; i++)
			mem[i] = 8'hff;
	end

	//////////////////////////////////////////////////
	// Pin sampling on the system clock

	always @(posedge clk) begin : pins
		logic [7:0] rx_byte;
		logic [7:0] cur_op;
		logic [7:0] nxt;
		int         idx;
		sck_q <= spi_sck;
		cs_q  <= spi_cs_n;
		if (!rst_n) begin
			bit_cnt    <= '0;
			byte_cnt   <= 0;
			opcode     <= '0;
			addr       <= '0;
			rx_sh      <= '0;
			tx_sh      <= '0;
			nxt_byte   <= '0;
			wel        <= 1'b0;
			busy_left  <= 0;
			busy_polls <= '0;
			spi_miso   <= 1'b0;
		end else if (spi_cs_n) begin
			bit_cnt  <= '0;
			byte_cnt <= 0;
			if (!cs_q && byte_cnt > 0) begin
				// CS rising ends the command
				case (opcode)
					8'h06: wel <= 1'b1;
					8'h02: if (wel) begin
						busy_left <= int'(busy_reads);
						wel       <= 1'b0;
					end
					8'hd8, 8'h60: if (wel) begin
						for (int i = 0; i < MEM_BYTES; i++)
							mem[i] <= 8'hff; // One sector is the whole array
						busy_left <= int'(busy_reads);
						wel       <= 1'b0;
					end
					default: ;
				endcase
			end
		end else if (spi_sck && !sck_q) begin
			// SCK rise, MOSI in
			rx_byte = {rx_sh[6:0], spi_mosi};
			cur_op  = (byte_cnt == 0) ? rx_byte : opcode;
			rx_sh   <= rx_byte;
			bit_cnt <= bit_cnt + 1'b1;
			if (bit_cnt == 3'd7) begin
				byte_cnt <= byte_cnt + 1;
				nxt = 8'h00;
				idx = int'(addr[11:0]) + byte_cnt - 4;
				if (byte_cnt == 0)
					opcode <= rx_byte;
				else if (byte_cnt <= 3)
					addr <= {addr[15:0], rx_byte}; // MSB first
				if (cur_op == 8'h05) begin
					nxt = {7'd0, busy_left != 0}; // SR1 bit 0
					if (busy_left != 0) begin
						busy_left  <= busy_left - 1;
						busy_polls <= busy_polls + 1;
					end
				end else if (cur_op == 8'h0b && byte_cnt >= 4) begin
					nxt = mem[idx[11:0]]; // After the dummy byte
				end else if (cur_op == 8'h02 && byte_cnt >= 4 && wel) begin
					mem[idx[11:0]] <= mem[idx[11:0]] & rx_byte; // Bits only clear
				end
				nxt_byte <= nxt;
			end
		end else if (!spi_sck && sck_q) begin
			// SCK fall, next MISO bit
			if (bit_cnt == 3'd0) begin
				spi_miso <= nxt_byte[7];
				tx_sh    <= {nxt_byte[6:0], 1'b0};
			end else begin
				spi_miso <= tx_sh[7];
				tx_sh    <= {tx_sh[6:0], 1'b0};
			end
		end
	end

endmodule

// ==== testbench/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen #(
	parameter real PERIOD_NS   = 10.0,
	parameter int  RESET_TICKS = 16
) (
	output logic clk,
	output logic rst_n
);

	initial clk = 1'b0;
	always #(PERIOD_NS / 2.0) clk = !clk; // Free running

	// Reset held low, released on a rising edge
	initial begin
		rst_n = 1'b0;
		repeat (RESET_TICKS) @(posedge clk);
		rst_n <= 1'b1;
	end

endmodule

// ==== design/qspi_flash_ctrl.sv ====
`timescale 1ns/1ps
`include "qspi_flash_defines.svh"

module qspi_flash_ctrl (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic [`QSPI_CLKDIV_W-1:0] clkdiv,
	input  logic                      cmd_en,
	input  flash_cmd_pkg::host_cmd_t  cmd_id,
	input  logic [`QSPI_ADDR_W-1:0]   cmd_addr,
	input  logic [`QSPI_LEN_W-1:0]    cmd_len,
	output logic [7:0]                read_data,
	output logic                      read_valid,
	input  logic [7:0]                write_data,
	input  logic                      write_valid,
	output logic                      write_ready,
	output logic                      busy,
	output logic                      spi_sck,
	output logic                      spi_mosi,
	input  logic                      spi_miso,
	output logic                      spi_cs_n
);

	logic       eng_shift_en, eng_cs_n, eng_shift_done;
	logic [7:0] eng_tx_data;
	logic       pol_shift_en, pol_cs_n, pol_shift_done;
	logic [7:0] pol_tx_data;
	logic       poll_start, poll_done;
	logic       shift_en, shift_done;
	logic [7:0] tx_data, rx_data;

	spi_byte_shifter i_shifter (
		.clk, .rst_n, .clkdiv, .shift_en, .tx_data, .shift_done, .rx_data,
		.spi_sck, .spi_mosi, .spi_miso
	);

	spi_bus_arbiter i_arbiter (
		.clk, .rst_n, .eng_shift_en, .eng_tx_data, .eng_cs_n,
		.pol_shift_en, .pol_tx_data, .pol_cs_n, .poll_start, .poll_done,
		.shift_en, .tx_data, .shift_done, .rx_data,
		.eng_shift_done, .pol_shift_done, .spi_cs_n
	);

	flash_cmd_engine i_engine (
		.clk, .rst_n, .cmd_en, .cmd_id, .cmd_addr, .cmd_len,
		.read_data, .read_valid, .write_data, .write_valid, .write_ready, .busy,
		.shift_en(eng_shift_en), .tx_data(eng_tx_data), .cs_n(eng_cs_n),
		.shift_done(eng_shift_done), .rx_data, .poll_start, .poll_done
	);

	// Status polling after program and erase
	flash_busy_poller i_poller (
		.clk, .rst_n, .poll_start, .poll_done,
		.shift_en(pol_shift_en), .tx_data(pol_tx_data), .cs_n(pol_cs_n),
		.shift_done(pol_shift_done), .rx_data
	);

endmodule

// ==== design/flash_busy_poller.sv ====
`timescale 1ns/1ps
`include "qspi_flash_defines.svh"

module flash_busy_poller (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       poll_start,
	output logic       poll_done,
	output logic       shift_en,
	output logic [7:0] tx_data,
	output logic       cs_n,
	input  logic       shift_done,
	input  logic [7:0] rx_data
);

	typedef enum logic [1:0] {
		POL_IDLE   = 2'd0,
		POL_OPCODE = 2'd1, // 05h in flight
		POL_STATUS = 2'd2, // Status bytes streaming
		POL_GAP    = 2'd3
	} poll_state_t;

	poll_state_t              state;
	logic [`QSPI_GAP_W-1:0]   gap_cnt;
	spi_bus_pkg::bus_master_t bus_view;

	assign bus_view = (state == POL_IDLE) ? spi_bus_pkg::MASTER_ENGINE
	                                      : spi_bus_pkg::MASTER_POLLER;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state     <= POL_IDLE;
			gap_cnt   <= '0;
			cs_n      <= 1'b1;
			shift_en  <= 1'b0;
			tx_data   <= '0;
			poll_done <= 1'b0;
		end else begin
			shift_en  <= 1'b0;
			poll_done <= 1'b0;
			case (state)
				POL_IDLE: if (poll_start) begin
					cs_n     <= 1'b0;
					shift_en <= 1'b1;
					tx_data  <= flash_cmd_pkg::OP_READ_SR1;
					state    <= POL_OPCODE;
				end
				POL_OPCODE: if (shift_done) begin
					shift_en <= 1'b1;
					tx_data  <= 8'h00;
					state    <= POL_STATUS;
				end
				// SR1 repeats for as long as CS stays low
				POL_STATUS: if (shift_done) begin
					if (rx_data[0]) begin
						shift_en <= 1'b1; // Still busy
						tx_data  <= 8'h00;
					end else begin
						cs_n    <= 1'b1;
						gap_cnt <= 1;
						state   <= POL_GAP;
					end
				end
				default: begin
					gap_cnt <= gap_cnt + 1'b1;
					if (gap_cnt == `QSPI_CS_GAP - 1) begin
						poll_done <= 1'b1; // Bus back to the engine
						state     <= POL_IDLE;
					end
				end
			endcase
		end
	end

	a_single_poll: assert property (@(posedge clk) disable iff (!rst_n)
		poll_start |-> bus_view == spi_bus_pkg::MASTER_ENGINE);
	a_done_when_owner: assert property (@(posedge clk) disable iff (!rst_n)
		shift_done |-> bus_view == spi_bus_pkg::MASTER_POLLER);

endmodule

// ==== design/flash_cmd_engine.sv ====
`timescale 1ns/1ps
`include "qspi_flash_defines.svh"

module flash_cmd_engine (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     cmd_en,
	input  flash_cmd_pkg::host_cmd_t cmd_id,
	input  logic [`QSPI_ADDR_W-1:0]  cmd_addr,
	input  logic [`QSPI_LEN_W-1:0]   cmd_len,
	output logic [7:0]               read_data,
	output logic                     read_valid,
	input  logic [7:0]               write_data,
	input  logic                     write_valid,
	output logic                     write_ready,
	output logic                     busy,
	output logic                     shift_en,
	output logic [7:0]               tx_data,
	output logic                     cs_n,
	input  logic                     shift_done,
	input  logic [7:0]               rx_data,
	output logic                     poll_start,
	input  logic                     poll_done
);

	flash_cmd_pkg::engine_state_t state;
	flash_cmd_pkg::engine_state_t ret_state; // Where ADDRESS and GAP go next
	logic [`QSPI_LEN_W-1:0]            count;     // Data bytes sent
	logic [$clog2(`QSPI_ADDR_BYTES)-1:0] addr_idx;
	logic [`QSPI_GAP_W-1:0]            gap_cnt;
	logic [7:0]                        wbuf;       // One-byte write buffer
	logic                              wbuf_valid;
	logic                              stalled;    // Program waiting on host data
	spi_bus_pkg::bus_master_t          bus_view;   // Owner as the engine sees it

	assign busy     = (state != flash_cmd_pkg::ST_IDLE);
	assign bus_view = (state == flash_cmd_pkg::ST_WAIT_POLL) ? spi_bus_pkg::MASTER_POLLER
	                                                         : spi_bus_pkg::MASTER_ENGINE;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state       <= flash_cmd_pkg::ST_IDLE;
			ret_state   <= flash_cmd_pkg::ST_IDLE;
			count       <= '0;
			addr_idx    <= '0;
			gap_cnt     <= '0;
			wbuf_valid  <= 1'b0;
			stalled     <= 1'b0;
			cs_n        <= 1'b1;
			shift_en    <= 1'b0;
			tx_data     <= '0;
			read_valid  <= 1'b0;
			write_ready <= 1'b0;
			poll_start  <= 1'b0;
		end else begin
			shift_en    <= 1'b0; // Pulses
			read_valid  <= 1'b0;
			write_ready <= 1'b0;
			poll_start  <= 1'b0;

			case (state)
				//////////////////////////////////////////////////
				// Dispatch
				flash_cmd_pkg::ST_IDLE: begin
					count    <= '0;
					addr_idx <= '0;
					if (cmd_en) begin
						cs_n     <= 1'b0;
						shift_en <= 1'b1;
						if (cmd_id == flash_cmd_pkg::HOST_READ) begin
							tx_data   <= flash_cmd_pkg::OP_FAST_READ;
							ret_state <= flash_cmd_pkg::ST_DUMMY;
							state     <= flash_cmd_pkg::ST_ADDRESS;
						end else begin
							tx_data   <= flash_cmd_pkg::OP_WRITE_ENABLE; // All writes start with WE
							ret_state <= flash_cmd_pkg::ST_IDLE;
							state     <= flash_cmd_pkg::ST_WRITE_ENABLE;
						end
					end
				end

				flash_cmd_pkg::ST_WRITE_ENABLE: begin
					if (ret_state != flash_cmd_pkg::ST_WRITE_ENABLE) begin
						// 06h still in flight
						if (shift_done) begin
							cs_n      <= 1'b1;
							gap_cnt   <= 1;
							ret_state <= flash_cmd_pkg::ST_WRITE_ENABLE;
							state     <= flash_cmd_pkg::ST_GAP;
						end
					end else begin
						// Back from the gap, send the real opcode
						cs_n     <= 1'b0;
						shift_en <= 1'b1;
						case (cmd_id)
							flash_cmd_pkg::HOST_PROGRAM: begin
								tx_data     <= flash_cmd_pkg::OP_PAGE_PROGRAM;
								ret_state   <= flash_cmd_pkg::ST_WRITE;
								state       <= flash_cmd_pkg::ST_ADDRESS;
								write_ready <= 1'b1; // First data byte wanted early
							end
							flash_cmd_pkg::HOST_ERASE: begin
								tx_data   <= flash_cmd_pkg::OP_SECTOR_ERASE;
								ret_state <= flash_cmd_pkg::ST_ERASE_WAIT;
								state     <= flash_cmd_pkg::ST_ADDRESS;
							end
							default: begin
								tx_data <= flash_cmd_pkg::OP_BULK_ERASE; // Wipe, no address
								state   <= flash_cmd_pkg::ST_ERASE_WAIT;
							end
						endcase
					end
				end

				// MSB first, last byte leaves with ret_state taking over
				flash_cmd_pkg::ST_ADDRESS: begin
					if (shift_done) begin
						shift_en <= 1'b1;
						tx_data  <= cmd_addr[8 * (`QSPI_ADDR_BYTES - 1 - addr_idx) +: 8];
						addr_idx <= addr_idx + 1'b1;
						if (addr_idx == `QSPI_ADDR_BYTES - 1)
							state <= ret_state;
					end
				end

				flash_cmd_pkg::ST_DUMMY: begin
					if (shift_done) begin
						shift_en <= 1'b1;
						tx_data  <= 8'h00;
						count    <= '0;
						state    <= flash_cmd_pkg::ST_READ;
					end
				end

				//////////////////////////////////////////////////
				// Data phases
				flash_cmd_pkg::ST_READ: begin
					if (shift_done) begin
						read_valid <= (count != 0); // Skip the dummy byte
						if (count == cmd_len) begin
							cs_n      <= 1'b1;
							gap_cnt   <= 1;
							ret_state <= flash_cmd_pkg::ST_IDLE;
							state     <= flash_cmd_pkg::ST_GAP;
						end else begin
							shift_en <= 1'b1;
							tx_data  <= 8'h00;
							count    <= count + 1'b1;
						end
					end
				end

				flash_cmd_pkg::ST_WRITE: begin
					if (shift_done || stalled) begin
						if (count == cmd_len) begin
							cs_n      <= 1'b1;
							gap_cnt   <= 1;
							ret_state <= flash_cmd_pkg::ST_WAIT_POLL;
							state     <= flash_cmd_pkg::ST_GAP;
						end else if (wbuf_valid) begin
							shift_en    <= 1'b1;
							tx_data     <= wbuf;
							count       <= count + 1'b1;
							wbuf_valid  <= 1'b0;
							stalled     <= 1'b0;
							write_ready <= (count + 1'b1 != cmd_len);
						end else begin
							stalled <= 1'b1; // Host late, CS stays low
						end
					end
				end

				flash_cmd_pkg::ST_ERASE_WAIT: begin
					if (shift_done) begin
						cs_n      <= 1'b1;
						gap_cnt   <= 1;
						ret_state <= flash_cmd_pkg::ST_WAIT_POLL;
						state     <= flash_cmd_pkg::ST_GAP;
					end
				end

				// Next state's first cycle still has CS high
				flash_cmd_pkg::ST_GAP: begin
					gap_cnt <= gap_cnt + 1'b1;
					if (gap_cnt == `QSPI_CS_GAP - 1) begin
						state      <= ret_state;
						poll_start <= (ret_state == flash_cmd_pkg::ST_WAIT_POLL);
					end
				end

				flash_cmd_pkg::ST_WAIT_POLL: begin
					if (poll_done)
						state <= flash_cmd_pkg::ST_IDLE;
				end

				default: state <= flash_cmd_pkg::ST_IDLE;
			endcase

			if (write_valid)
				wbuf_valid <= 1'b1;
		end
	end

	// Payload, no reset
	always_ff @(posedge clk) begin
		if (write_valid)
			wbuf <= write_data;
		if (state == flash_cmd_pkg::ST_READ && shift_done)
			read_data <= rx_data;
	end

	// Arbiter must gate done while the poller owns the bus
	a_done_when_owner: assert property (@(posedge clk) disable iff (!rst_n)
		shift_done |-> bus_view == spi_bus_pkg::MASTER_ENGINE);
	a_done_only_polling: assert property (@(posedge clk) disable iff (!rst_n)
		poll_done |-> bus_view == spi_bus_pkg::MASTER_POLLER);

endmodule

// ==== design/spi_bus_arbiter.sv ====
`timescale 1ns/1ps

module spi_bus_arbiter (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       eng_shift_en,
	input  logic [7:0] eng_tx_data,
	input  logic       eng_cs_n,
	input  logic       pol_shift_en,
	input  logic [7:0] pol_tx_data,
	input  logic       pol_cs_n,
	input  logic       poll_start,
	input  logic       poll_done,
	output logic       shift_en,
	output logic [7:0] tx_data,
	input  logic       shift_done,
	input  logic [7:0] rx_data,
	output logic       eng_shift_done,
	output logic       pol_shift_done,
	output logic       spi_cs_n
);

	spi_bus_pkg::arb_state_t  owner;
	spi_bus_pkg::bus_master_t master;

	// Hand over only on the two handshake pulses
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			owner <= spi_bus_pkg::ARB_ENGINE;
		else if (poll_start)
			owner <= spi_bus_pkg::ARB_POLLER;
		else if (poll_done)
			owner <= spi_bus_pkg::ARB_ENGINE;
	end

	assign master = (owner == spi_bus_pkg::ARB_POLLER) ? spi_bus_pkg::MASTER_POLLER
	                                                   : spi_bus_pkg::MASTER_ENGINE;

	//////////////////////////////////////////////////
	// Request mux and done gating

	always_comb begin
		shift_en = (master == spi_bus_pkg::MASTER_POLLER) ? pol_shift_en : eng_shift_en;
		tx_data  = (master == spi_bus_pkg::MASTER_POLLER) ? pol_tx_data : eng_tx_data;
		eng_shift_done = shift_done && (master == spi_bus_pkg::MASTER_ENGINE);
		pol_shift_done = shift_done && (master == spi_bus_pkg::MASTER_POLLER);
	end

	// Registered pin, no glitch at handover
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			spi_cs_n <= 1'b1;
		else
			spi_cs_n <= (master == spi_bus_pkg::MASTER_POLLER) ? pol_cs_n : eng_cs_n;
	end

	a_engine_quiet: assert property (@(posedge clk) disable iff (!rst_n)
		(master == spi_bus_pkg::MASTER_POLLER) |-> !eng_shift_en);
	a_poller_quiet: assert property (@(posedge clk) disable iff (!rst_n)
		(master == spi_bus_pkg::MASTER_ENGINE) |-> !pol_shift_en);
	a_start_from_engine: assert property (@(posedge clk) disable iff (!rst_n)
		poll_start |-> owner == spi_bus_pkg::ARB_ENGINE);
	// Received byte is defined whenever either peer may take it
	a_rx_known: assert property (@(posedge clk) disable iff (!rst_n)
		shift_done |-> !$isunknown(rx_data));

endmodule

// ==== design/spi_byte_shifter.sv ====
`timescale 1ns/1ps
`include "qspi_flash_defines.svh"

module spi_byte_shifter (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic [`QSPI_CLKDIV_W-1:0] clkdiv,
	input  logic                      shift_en,
	input  logic [7:0]                tx_data,
	output logic                      shift_done,
	output logic [7:0]                rx_data,
	output logic                      spi_sck,
	output logic                      spi_mosi,
	input  logic                      spi_miso
);

	logic                      active;   // Byte in progress
	logic [`QSPI_CLKDIV_W-1:0] div_cnt;  // Clocks within a half period
	logic [3:0]                edge_cnt; // SCK edges so far, even ones rise
	logic [7:0]                shreg;    // Out at the top, in at the bottom
	logic                      half_end;

	assign half_end = active && (div_cnt == clkdiv);

	//////////////////////////////////////////////////
	// Divider and edge sequencing

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			active     <= 1'b0;
			div_cnt    <= '0;
			edge_cnt   <= '0;
			spi_sck    <= 1'b0; // Mode 0 idles low
			spi_mosi   <= 1'b0;
			shift_done <= 1'b0;
		end else begin
			shift_done <= 1'b0;
			if (shift_en) begin
				active   <= 1'b1;
				div_cnt  <= '0;
				edge_cnt <= '0;
				spi_mosi <= tx_data[7]; // MSB ready before the first rise
			end else if (active) begin
				if (half_end) begin
					div_cnt  <= '0;
					spi_sck  <= !spi_sck;
					edge_cnt <= edge_cnt + 1'b1;
					if (spi_sck) begin
						// Falling edge, present next bit
						spi_mosi <= shreg[7];
						if (edge_cnt == 4'd15) begin
							active     <= 1'b0; // SCK back low after the 8th rise
							shift_done <= 1'b1;
						end
					end
				end else begin
					div_cnt <= div_cnt + 1'b1;
				end
			end
		end
	end

	// Data path, sampled as SCK rises
	always_ff @(posedge clk) begin
		if (shift_en)
			shreg <= tx_data;
		else if (half_end && !spi_sck)
			shreg <= {shreg[6:0], spi_miso};
	end

	assign rx_data = shreg; // Stable while shift_done is high

	// Peers wait for shift_done before asking again
	a_no_overlap: assert property (@(posedge clk) disable iff (!rst_n)
		active |-> !shift_en);

endmodule

// ==== design/spi_bus_pkg.sv ====
package spi_bus_pkg;

	// Which peer drives the shifter
	typedef enum logic {
		MASTER_ENGINE = 1'b0,
		MASTER_POLLER = 1'b1
	} bus_master_t;

	// Arbiter ownership register
	typedef enum logic {
		ARB_ENGINE = 1'b0, // Default after reset
		ARB_POLLER = 1'b1
	} arb_state_t;

endpackage

// ==== design/flash_cmd_pkg.sv ====
package flash_cmd_pkg;

	// Commands the host may issue
	typedef enum logic [1:0] {
		HOST_READ    = 2'd0, // Fast read, one dummy byte
		HOST_PROGRAM = 2'd1, // Page program
		HOST_ERASE   = 2'd2, // Sector erase
		HOST_WIPE    = 2'd3  // Whole chip
	} host_cmd_t;

	// Standard serial NOR opcodes
	typedef enum logic [7:0] {
		OP_PAGE_PROGRAM = 8'h02,
		OP_READ_SR1     = 8'h05, // Bit 0 is busy
		OP_WRITE_ENABLE = 8'h06,
		OP_FAST_READ    = 8'h0b,
		OP_BULK_ERASE   = 8'h60,
		OP_SECTOR_ERASE = 8'hd8
	} flash_opcode_t;

	// Command engine FSM
	typedef enum logic [3:0] {
		ST_IDLE         = 4'h0,
		ST_WRITE_ENABLE = 4'h1, // 06h in flight, or back from the gap
		ST_ADDRESS      = 4'h2,
		ST_DUMMY        = 4'h3,
		ST_READ         = 4'h4,
		ST_WRITE        = 4'h5,
		ST_ERASE_WAIT   = 4'h6, // Last erase byte in flight
		ST_GAP          = 4'h7,
		ST_WAIT_POLL    = 4'h8  // Poller owns the bus
	} engine_state_t;

endpackage

// ==== design/qspi_flash_defines.svh ====
`ifndef QSPI_FLASH_DEFINES_SVH
`define QSPI_FLASH_DEFINES_SVH

//////////////////////////////////////////////////
// SPI clock divider

// Half period of SCK is clkdiv+1 clk cycles
`define QSPI_CLKDIV_W 16

//////////////////////////////////////////////////
// Command geometry

`define QSPI_LEN_W 16 // Data byte count per command

// Always 24-bit addressing
`define QSPI_ADDR_BYTES 3
`define QSPI_ADDR_W (8 * `QSPI_ADDR_BYTES)

//////////////////////////////////////////////////
// Chip select timing

// CS high time between two transactions, clk cycles
`define QSPI_CS_GAP 4
`define QSPI_GAP_W ($clog2(`QSPI_CS_GAP + 1)) // Gap counter width

`endif
